// File: all.f
design/dcache_pkg.sv
design/dcache_array_if.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_rd_ctrl.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/wb_mem_model.sv
bench/tb_dcache.sv

// File: bench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    logic        clk = 1'b0;
    logic        rst;
    logic        cpu_cyc;
    logic        cpu_stb;
    logic        cpu_we;
    logic [31:0] cpu_adr;
    logic [3:0]  cpu_sel;
    logic [31:0] cpu_dat_w;
    logic        cpu_signed;
    logic        cpu_uncache;
    logic [31:0] cpu_dat_r;
    logic        cpu_ack;
    logic        mem_cyc;
    logic        mem_stb;
    logic        mem_we;
    logic [31:0] mem_adr;
    logic [3:0]  mem_sel;
    logic [31:0] mem_dat_w;
    logic [31:0] mem_dat_r;
    logic        mem_ack;

    // reference model of the memory image and the expected cache contents
    logic [31:0] shadow_mem [1024];
    logic [31:0] line_mem [16][4][16];
    logic [21:0] line_tag [16][4];
    logic        line_valid [16][4];
    logic [1:0]  rr_next [16];
    logic [3:0]  sel_list [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
    logic [31:0] exp_data;
    int          exp_reads;
    int          exp_writes;
    logic        exp_hit;
    int          mem_reads;
    int          mem_writes;
    int          stb_edges;
    logic [31:0] rng;

    always #50 clk = ~clk;

    dcache_top u_dcache_top (.*);

    wb_mem_model u_mem (
        .clk   (clk),       .rst   (rst),       .cyc   (mem_cyc),   .stb (mem_stb),
        .we    (mem_we),    .adr   (mem_adr),   .sel   (mem_sel),   .dat_w (mem_dat_w),
        .dat_r (mem_dat_r), .ack   (mem_ack)
    );

    always @(posedge clk) begin
        if (!cpu_stb) begin
            stb_edges  <= 0;
            mem_reads  <= 0;
            mem_writes <= 0;
        end else begin
            stb_edges <= stb_edges + 1;
            if (mem_ack && !mem_we) mem_reads <= mem_reads + 1;
            if (mem_ack && mem_we) mem_writes <= mem_writes + 1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    a_reset_idle: assert property (@(posedge clk) $past(rst) && !rst |->
        !cpu_ack && !mem_cyc && !mem_stb && !mem_we)
        else abort_run("bus outputs were active right after reset");

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        cpu_ack && !cpu_we |-> cpu_dat_r == exp_data)
        else abort_run($sformatf("[FAIL] cpu_dat_r %h, expected %h (cpu_adr %h)",
            $sampled(cpu_dat_r), exp_data, cpu_adr));

    a_mem_traffic: assert property (@(posedge clk) disable iff (rst)
        cpu_ack |-> mem_reads == exp_reads && mem_writes == exp_writes)
        else abort_run($sformatf("[FAIL] mem_reads %h mem_writes %h, expected %h and %h",
            $sampled(mem_reads), $sampled(mem_writes), exp_reads, exp_writes));

    // stb is taken at the first edge and the hit ack is set two edges later
    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        cpu_ack && exp_hit |-> stb_edges == 3)
        else abort_run($sformatf("[FAIL] stb_edges %h at cpu_ack, expected %h",
            $sampled(stb_edges), 3));

    a_hit_quiet: assert property (@(posedge clk) disable iff (rst)
        cpu_stb && exp_hit |-> !mem_cyc)
        else abort_run($sformatf("[FAIL] mem_cyc %h during a hit, expected %h", 1'b1, 1'b0));

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] dat,
                                                input logic [3:0] sel);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) old[b * 8 +: 8] = dat[b * 8 +: 8];
        end
        return old;
    endfunction

    function automatic logic [31:0] extend_lane(input logic [31:0] w, input logic [3:0] sel,
                                                input logic sgn);
        logic [7:0] b;
        case (sel)
            4'b0001: b = w[7:0];
            4'b0010: b = w[15:8];
            4'b0100: b = w[23:16];
            4'b1000: b = w[31:24];
            4'b0011: return {{16{sgn & w[15]}}, w[15:0]};
            4'b1100: return {{16{sgn & w[31]}}, w[31:16]};
            default: return w;
        endcase
        return {{24{sgn & b[7]}}, b};
    endfunction

    task automatic model_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                                input logic [31:0] dat, input logic sgn, input logic unc);
        logic [3:0] set;
        logic [3:0] w;
        logic [31:0] src;
        int way;
        set = adr[9:6];
        w = adr[5:2];
        src = '0;
        way = -1;
        for (int i = 0; i < 4; i++) begin
            if (!unc && line_valid[set][i] && line_tag[set][i] == adr[31:10]) way = i;
        end
        exp_hit = 1'b0;
        exp_reads = 0;
        exp_writes = we ? 1 : 0;
        if (we) begin
            shadow_mem[adr[11:2]] = merge_bytes(shadow_mem[adr[11:2]], dat, sel);
            if (way >= 0) line_mem[set][way][w] = merge_bytes(line_mem[set][way][w], dat, sel);
        end else if (unc) begin
            exp_reads = 1;
            src = shadow_mem[adr[11:2]];
        end else if (way >= 0) begin
            exp_hit = 1'b1;
            src = line_mem[set][way][w];
        end else begin
            exp_reads = 16;  // the whole line comes in and replaces the round-robin victim
            way = rr_next[set];
            for (int k = 0; k < 16; k++) line_mem[set][way][k] = shadow_mem[{adr[11:6], 4'(k)}];
            line_tag[set][way] = adr[31:10];
            line_valid[set][way] = 1'b1;
            rr_next[set] = rr_next[set] + 2'd1;
            src = line_mem[set][way][w];
        end
        exp_data = extend_lane(src, sel, sgn);
    endtask

    task automatic do_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat, input logic sgn, input logic unc);
        int waited;
        model_access(we, adr, sel, dat, sgn, unc);
        cpu_cyc     = 1'b1;
        cpu_stb     = 1'b1;
        cpu_we      = we;
        cpu_adr     = adr;
        cpu_sel     = sel;
        cpu_dat_w   = dat;
        cpu_signed  = sgn;
        cpu_uncache = unc;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 500) abort_run("timeout while waiting for cpu_ack");
        end while (!cpu_ack);
        @(negedge clk);  // the ack edge has passed
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        rst         = 1'b1;
        cpu_cyc     = 1'b0;
        cpu_stb     = 1'b0;
        cpu_we      = 1'b0;
        cpu_adr     = '0;
        cpu_sel     = '0;
        cpu_dat_w   = '0;
        cpu_signed  = 1'b0;
        cpu_uncache = 1'b0;
        rng         = 32'd33;
        for (int s = 0; s < 16; s++) begin
            rr_next[s] = '0;
            for (int w = 0; w < 4; w++) line_valid[s][w] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 1024; i++) shadow_mem[i] = u_mem.mem[i];

        do_access(0, 32'h4c, 4'hf, '0, 0, 0);  // cold miss, then the same word hits
        do_access(0, 32'h4c, 4'hf, '0, 0, 0);
        do_access(1, 32'h4c, 4'hf, 32'h8a7f_f501, 0, 0);
        do_access(1, 32'h50, 4'hf, 32'h7f80_00ff, 0, 0);
        for (int a = 0; a < 2; a++) begin
            for (int s = 0; s < 6; s++) begin
                do_access(0, 32'h4c + 32'(a * 4), sel_list[s], '0, 0, 0);
                do_access(0, 32'h4c + 32'(a * 4), sel_list[s], '0, 1, 0);
            end
        end
        do_access(1, 32'h4c, 4'b0100, 32'h00c3_0000, 0, 0);
        do_access(0, 32'h4c, 4'hf, '0, 0, 0);
        do_access(0, 32'h4c, 4'hf, '0, 0, 1);  // memory holds the same merged bytes
        do_access(1, 32'h58, 4'hf, 32'h1234_5678, 0, 1);  // uncached store leaves the line stale
        do_access(0, 32'h58, 4'hf, '0, 0, 0);
        do_access(0, 32'h58, 4'hf, '0, 0, 1);
        for (int t = 0; t < 5; t++) do_access(0, 32'((32 + t) << 10) | 32'h240, 4'hf, '0, 0, 0);
        do_access(0, 32'(32 << 10) | 32'h240, 4'hf, '0, 0, 0);

        for (int n = 0; n < 300; n++) begin
            rng = xorshift32(rng);
            r1  = rng;
            rng = xorshift32(rng);
            r2  = rng;
            do_access(r1[13:12] == 2'b00, {19'd0, r1[2:0], 2'b00, r1[4:3], r1[8:5], 2'b00},
                      sel_list[int'(r1[11:9]) % 7], r2, r1[17], r1[16:14] == 3'd0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [3:0]  sel,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);
    logic [31:0] mem [1024];   // 4 KB where higher address bits alias
    logic [31:0] rng;
    logic [1:0]  wait_left;
    logic        busy;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    initial begin
        ack   = 1'b0;
        dat_r = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h3c5a_96e1;  // odd multiplier keeps words distinct
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ack  <= 1'b0;
            busy <= 1'b0;
            rng  <= 32'd33;
        end else if (ack) begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end else if (cyc && stb) begin
            if (!busy) begin
                rng       <= xorshift32(rng);
                wait_left <= rng[1:0];  // 0 to 3 wait states for this cycle
                busy      <= 1'b1;
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (we && sel[b]) begin
                        mem[adr[11:2]][b * 8 +: 8] <= dat_w[b * 8 +: 8];
                    end
                end
                dat_r <= mem[adr[11:2]];
                ack   <= 1'b1;
            end
        end
    end

endmodule

// File: design/dcache_array_if.sv
`timescale 1ns/1ps

interface dcache_array_if;
    import dcache_pkg::*;

    logic [index_bits-1:0]          index;
    logic [3:0]                     word;
    logic [3:0]                     be;           // byte enables of a store word
    logic [31:0]                    wdata;
    logic [num_ways-1:0]            way_we;       // one-hot way being written
    line_t                          refill_line;
    logic                           refill_en;    // whole-line write instead of one word
    logic [num_ways*$bits(line_t)-1:0] rdata;    // way 0 in the low bits

    modport ctrl (
        output index,
        output word,
        output be,
        output wdata,
        output way_we,
        output refill_line,
        output refill_en,
        input  rdata
    );

    modport array (
        input  index,
        input  word,
        input  be,
        input  wdata,
        input  way_we,
        input  refill_line,
        input  refill_en,
        output rdata
    );

endinterface

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_cyc,
    input  logic                     cpu_stb,
    input  logic                     cpu_we,
    input  logic [31:0]              cpu_adr,
    input  logic [3:0]               cpu_sel,
    input  logic [31:0]              cpu_dat_w,
    input  logic                     cpu_signed,
    input  logic                     cpu_uncache,
    output logic [31:0]              cpu_dat_r,
    output logic                     cpu_ack,
    output logic                     mem_cyc,
    output logic                     mem_stb,
    output logic                     mem_we,
    output logic [31:0]              mem_adr,
    output logic [3:0]               mem_sel,
    output logic [31:0]              mem_dat_w,
    input  logic [31:0]              mem_dat_r,
    input  logic                     mem_ack,
    output logic [3:0]               lookup_index,
    output logic [21:0]              lookup_tag,
    output logic                     fill,
    output logic [3:0]               fill_way,
    input  logic [3:0]               hit_way,
    input  logic [3:0]               victim_way,
    dcache_array_if.ctrl             arr,
    output dcache_pkg::line_t        refill_line,
    output logic                     from_cache,
    output logic                     uncache_q,
    output logic [3:0]               word_q,
    output logic [3:0]               sel_q,
    output dcache_pkg::access_size_e size,
    output logic                     signed_q,
    input  logic [31:0]              rd_data
);
    import dcache_pkg::*;

    localparam logic [2:0] s_idle    = 3'd0;
    localparam logic [2:0] s_lookup  = 3'd1;
    localparam logic [2:0] s_compare = 3'd2;
    localparam logic [2:0] s_refill  = 3'd3;
    localparam logic [2:0] s_mem_wr  = 3'd4;
    localparam logic [2:0] s_unc_rd  = 3'd5;
    localparam logic [2:0] s_resp    = 3'd6;

    logic [2:0]  state;
    logic [2:0]  state_next;
    dc_addr_u    addr_q;
    logic        we_q;
    logic [31:0] dat_w_q;
    logic [31:0] dat_q;
    logic [3:0]  cnt;
    logic        miss_q;
    line_t       line_buf;
    logic        hit;
    logic        mem_busy;
    logic        mem_rd_ack;

    assign hit        = |hit_way;
    assign mem_busy   = (state == s_refill) || (state == s_mem_wr) || (state == s_unc_rd);
    assign mem_rd_ack = mem_ack && ((state == s_refill) || (state == s_unc_rd));

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (cpu_cyc && cpu_stb) begin
                    if (cpu_uncache) begin
                        state_next = cpu_we ? s_mem_wr : s_unc_rd;  // no lookup at all
                    end else begin
                        state_next = s_lookup;
                    end
                end
            end
            s_lookup:  state_next = s_compare;
            s_compare: state_next = we_q ? s_mem_wr : (hit ? s_resp : s_refill);
            s_refill:  if (mem_ack && cnt == 4'(line_words - 1)) state_next = s_resp;
            s_mem_wr:  if (mem_ack) state_next = s_resp;
            s_unc_rd:  if (mem_ack) state_next = s_resp;
            default:   state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= s_idle;
            cnt    <= '0;
            miss_q <= 1'b0;
        end else begin
            state <= state_next;
            if (state == s_idle) begin
                cnt    <= '0;
                miss_q <= 1'b0;
            end
            if (state == s_compare && !we_q && !hit) begin
                miss_q <= 1'b1;
            end
            if (state == s_refill && mem_ack) begin
                cnt <= cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && cpu_cyc && cpu_stb) begin
            addr_q.raw <= cpu_adr;
            we_q       <= cpu_we;
            sel_q      <= cpu_sel;
            dat_w_q    <= cpu_dat_w;
            signed_q   <= cpu_signed;
            uncache_q  <= cpu_uncache;
        end
        if (state == s_compare) begin
            fill_way <= victim_way;
        end
        if (mem_rd_ack) begin
            line_buf <= refill_line;
        end
        if (state_next == s_resp) begin
            dat_q <= rd_data;  // the answer is ready in the cycle before ack
        end
    end

    // refill buffer with the word arriving this cycle already merged in
    always_comb begin
        refill_line = line_buf;
        if (mem_rd_ack) begin
            refill_line[cnt * 32 +: 32] = mem_dat_r;
        end
    end

    always_comb begin
        case (sel_q)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: size = size_byte;
            4'b0011, 4'b1100:                   size = size_half;
            default:                            size = size_word;
        endcase
    end

    assign lookup_index = addr_q.f.index;
    assign lookup_tag   = addr_q.f.tag;
    assign word_q       = addr_q.f.word;
    assign fill         = (state == s_resp) && miss_q;
    assign from_cache   = (state == s_compare);

    assign cpu_ack   = (state == s_resp);
    assign cpu_dat_r = dat_q;

    assign mem_cyc   = mem_busy;
    assign mem_stb   = mem_busy;
    assign mem_we    = (state == s_mem_wr);
    assign mem_sel   = mem_we ? sel_q : 4'b1111;
    assign mem_dat_w = dat_w_q;
    assign mem_adr   = (state == s_refill) ? {addr_q.f.tag, addr_q.f.index, cnt, 2'b00}
                                           : {addr_q.raw[31:2], 2'b00};

    assign arr.index       = addr_q.f.index;
    assign arr.word        = addr_q.f.word;
    assign arr.be          = sel_q;
    assign arr.wdata       = dat_w_q;
    assign arr.refill_line = line_buf;
    assign arr.refill_en   = fill;

    always_comb begin
        if (fill) begin
            arr.way_we = fill_way;
        end else if (state == s_compare && we_q && hit) begin
            arr.way_we = hit_way;  // a store hit goes on to the memory write as well
        end else begin
            arr.way_we = '0;
        end
    end

    a_ack_with_stb: assert property (@(posedge clk) disable iff (rst) cpu_ack |-> cpu_stb)
        else $error("cpu_ack without cpu_stb");

    a_mem_adr_hold: assert property (@(posedge clk) disable iff (rst)
        mem_stb && !mem_ack |=> $stable(mem_adr))
        else $error("mem_adr changed to %h before mem_ack", mem_adr);

endmodule

// File: design/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array (
    input logic           clk,
    dcache_array_if.array arr
);
    import dcache_pkg::*;

    line_t mem [num_ways][num_sets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (arr.way_we[w] && arr.refill_en) begin
                mem[w][arr.index] <= arr.refill_line;
            end else if (arr.way_we[w]) begin
                // store hit merges only the enabled bytes of one word
                for (int b = 0; b < 4; b++) begin
                    if (arr.be[b]) begin
                        mem[w][arr.index][arr.word * 32 + b * 8 +: 8] <= arr.wdata[b * 8 +: 8];
                    end
                end
            end
            arr.rdata[w * $bits(line_t) +: $bits(line_t)] <= mem[w][arr.index];
        end
    end

    a_one_way_we: assert property (@(posedge clk) $onehot0(arr.way_we))
        else $error("way_we %b writes more than one way", arr.way_we);

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    localparam int line_words = 16;  // 32-bit words per line
    localparam int num_ways   = 4;
    localparam int index_bits = 4;
    localparam int tag_bits   = 22;  // address bits 31 down to 10
    localparam int num_sets   = 1 << index_bits;

    typedef logic [line_words*32-1:0] line_t;

    // derived from the byte selects of the request
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } access_size_e;

    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [index_bits-1:0] index;
        logic [3:0]            word;
        logic [1:0]            byte_off;
    } dc_addr_fields_t;

    // the same request address seen whole or split into lookup fields
    typedef union packed {
        logic [31:0]     raw;
        dc_addr_fields_t f;
    } dc_addr_u;

endpackage

// File: design/dcache_rd_ctrl.sv
`timescale 1ns/1ps

module dcache_rd_ctrl (
    input  logic [2047:0]            way_lines,
    input  logic [3:0]               hit_way,
    input  dcache_pkg::line_t        refill_line,
    input  logic                     from_cache,
    input  logic                     uncache,
    input  logic [3:0]               word,
    input  logic [3:0]               sel,
    input  dcache_pkg::access_size_e size,
    input  logic                     signed_ext,
    output logic [31:0]              rd_data
);
    import dcache_pkg::*;

    line_t       hit_line;
    logic [31:0] cache_word;
    logic [31:0] refill_word;
    logic [31:0] src_word;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w]) begin
                hit_line = hit_line | way_lines[w * $bits(line_t) +: $bits(line_t)];
            end
        end
    end

    assign cache_word  = hit_line[word * 32 +: 32];
    assign refill_word = uncache ? refill_line[31:0] : refill_line[word * 32 +: 32];  // uncached data lands in word 0
    assign src_word    = from_cache ? cache_word : refill_word;

    always_comb begin
        case (sel)
            4'b0010: lane_byte = src_word[15:8];
            4'b0100: lane_byte = src_word[23:16];
            4'b1000: lane_byte = src_word[31:24];
            default: lane_byte = src_word[7:0];
        endcase
    end

    assign lane_half = sel[2] ? src_word[31:16] : src_word[15:0];

    always_comb begin
        case (size)
            size_byte: rd_data = {{24{lane_byte[7] & signed_ext}}, lane_byte};
            size_half: rd_data = {{16{lane_half[15] & signed_ext}}, lane_half};
            default:   rd_data = src_word;
        endcase
    end

    // the size comes from the controller's decode of the registered selects
    always_comb begin
        if (size == size_half) begin
            a_half_sel: assert final (sel == 4'b0011 || sel == 4'b1100)
                else $error("half access with sel %b", sel);
        end
    end

endmodule

// File: design/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  lookup_index,
    input  logic [21:0] lookup_tag,
    input  logic        fill,
    input  logic [3:0]  fill_way,
    output logic [3:0]  hit_way,
    output logic [3:0]  victim_way
);
    import dcache_pkg::*;

    logic [tag_bits-1:0] tags [num_ways][num_sets];
    logic [num_ways-1:0] valid [num_sets];
    logic [1:0]          rr_ptr [num_sets];
    logic [tag_bits-1:0] tag_rd [num_ways];
    logic [num_ways-1:0] valid_rd;
    logic [tag_bits-1:0] cmp_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (fill) begin
            valid[lookup_index]  <= valid[lookup_index] | fill_way;
            rr_ptr[lookup_index] <= rr_ptr[lookup_index] + 2'd1;  // next victim in this set
        end
    end

    // tag storage and the registered read side
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (fill && fill_way[w]) begin
                tags[w][lookup_index] <= lookup_tag;
            end
            tag_rd[w] <= tags[w][lookup_index];
        end
        valid_rd   <= valid[lookup_index];
        cmp_tag    <= lookup_tag;
        victim_way <= 4'b0001 << rr_ptr[lookup_index];
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = valid_rd[w] && (tag_rd[w] == cmp_tag);
        end
    end

    // a tag is only filled after it missed in its set, so it never sits in two ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
        else $error("hit_way %b is not one-hot", hit_way);

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_cyc,
    input  logic        cpu_stb,
    input  logic        cpu_we,
    input  logic [31:0] cpu_adr,
    input  logic [3:0]  cpu_sel,
    input  logic [31:0] cpu_dat_w,
    input  logic        cpu_signed,
    input  logic        cpu_uncache,
    output logic [31:0] cpu_dat_r,
    output logic        cpu_ack,
    output logic        mem_cyc,
    output logic        mem_stb,
    output logic        mem_we,
    output logic [31:0] mem_adr,
    output logic [3:0]  mem_sel,
    output logic [31:0] mem_dat_w,
    input  logic [31:0] mem_dat_r,
    input  logic        mem_ack
);
    import dcache_pkg::*;

    logic [3:0]   lookup_index;
    logic [21:0]  lookup_tag;
    logic         fill;
    logic [3:0]   fill_way;
    logic [3:0]   hit_way;
    logic [3:0]   victim_way;
    line_t        refill_line;
    logic         from_cache;
    logic         uncache_q;
    logic [3:0]   word_q;
    logic [3:0]   sel_q;
    access_size_e size;
    logic         signed_q;
    logic [31:0]  rd_data;

    dcache_array_if arr ();

    dcache_ctrl u_ctrl (.*);

    dcache_tag_array u_tag_array (.*);

    dcache_data_array u_data_array (
        .clk (clk),
        .arr (arr)
    );

    dcache_rd_ctrl u_rd_ctrl (
        .way_lines   (arr.rdata),
        .hit_way     (hit_way),
        .refill_line (refill_line),
        .from_cache  (from_cache),
        .uncache     (uncache_q),
        .word        (word_q),
        .sel         (sel_q),
        .size        (size),
        .signed_ext  (signed_q),
        .rd_data     (rd_data)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dcache > "$log" 2>&1
status=$?
cat "$log"

if grep -q ">>> FAIL" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
